/* hw/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_AW    = 6;
    localparam int REG_AW     = 5;
    localparam int APB_AW     = 12;

    localparam logic [APB_AW-1:0] IMEM_BASE = 12'h000;
    localparam logic [APB_AW-1:0] DMEM_BASE = 12'h100;
    localparam logic [APB_AW-1:0] REG_BASE  = 12'h200;
    localparam logic [APB_AW-1:0] CTRL_ADDR = 12'h300;

    localparam int CTRL_RUN_BIT  = 0;
    localparam int CTRL_DONE_BIT = 1;

    localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        logic              use_imm;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              is_branch;
        logic              branch_ne;
        logic              is_halt;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              reg_write;
        logic [XLEN-1:0]   data;
        logic              is_halt;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                        sys_clk_i,
    input  logic                        sys_reset_i,
    input  logic                        run_i,
    input  logic                        stall_i,
    input  rv_pkg::redirect_t           redirect_i,
    input  logic                        imem_we_i,
    input  logic [rv_pkg::IMEM_AW-1:0]  imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0]     imem_wdata_i,
    output logic [rv_pkg::XLEN-1:0]     imem_rdata_o,
    output rv_pkg::if_id_t              if_id_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] fetch_word;
    logic            halted;

    assign fetch_word   = imem[pc[IMEM_AW+1:2]];
    assign imem_rdata_o = imem[imem_addr_i]; // host readback

    always_ff @(posedge sys_clk_i)
    begin
        if (imem_we_i)
            imem[imem_addr_i] <= imem_wdata_i;
    end

    always_ff @(posedge sys_clk_i or posedge sys_reset_i)
    begin
        if (sys_reset_i)
        begin
            pc      <= '0;
            halted  <= 1'b0;
            if_id_o <= '0;
        end
        else if (!run_i)
        begin
            pc            <= '0; // restart point for next run
            halted        <= 1'b0;
            if_id_o.valid <= 1'b0;
        end
        else if (redirect_i.taken)
        begin
            pc            <= redirect_i.target;
            halted        <= 1'b0; // ebreak in branch shadow
            if_id_o.valid <= 1'b0;
        end
        else if (!stall_i)
        begin
            if (halted)
                if_id_o.valid <= 1'b0;
            else
            begin
                if_id_o.valid <= 1'b1;
                if_id_o.pc    <= pc;
                if_id_o.instr <= fetch_word;
                pc            <= pc + 32'd4;
                halted        <= (fetch_word == INSTR_EBREAK); // freeze after ebreak
            end
        end
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                       sys_clk_i,
    input  logic                       sys_reset_i,
    input  rv_pkg::if_id_t             if_id_i,
    input  rv_pkg::redirect_t          redirect_i,
    input  rv_pkg::wb_t                wb_i,
    input  logic [rv_pkg::REG_AW-1:0]  dbg_reg_addr_i,
    output logic [rv_pkg::XLEN-1:0]    dbg_reg_data_o,
    output logic                       stall_o,
    output rv_pkg::id_ex_t             id_ex_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] instr;
    logic [2:0]      funct3;
    opcode_e         opcode;
    id_ex_t          nxt;

    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0)
            val = '0;
        else if (wb_i.valid && wb_i.reg_write && wb_i.rd == idx)
            val = wb_i.data; // write-through
        else
            val = regs[idx];
        return val;
    endfunction

    function automatic alu_op_e funct_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign instr  = if_id_i.instr;
    assign funct3 = instr[14:12];
    assign opcode = opcode_e'(instr[6:0]);

    assign dbg_reg_data_o = rf_read(dbg_reg_addr_i);

    // load in EX whose result is needed right now
    assign stall_o = if_id_i.valid && id_ex_o.valid && id_ex_o.mem_read
                     && id_ex_o.rd != '0
                     && (id_ex_o.rd == instr[19:15] || id_ex_o.rd == instr[24:20]);

    always_comb
    begin
        nxt          = '0;
        nxt.valid    = if_id_i.valid;
        nxt.pc       = if_id_i.pc;
        nxt.rs1      = instr[19:15];
        nxt.rs2      = instr[24:20];
        nxt.rd       = instr[11:7];
        nxt.rs1_data = rf_read(instr[19:15]);
        nxt.rs2_data = rf_read(instr[24:20]);
        nxt.alu_op   = ALU_ADD;
        case (opcode)
            OP:
            begin
                nxt.reg_write = 1'b1;
                nxt.alu_op    = funct_alu(funct3, instr[30]);
            end
            OP_IMM:
            begin
                nxt.reg_write = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = {{20{instr[31]}}, instr[31:20]};
                nxt.alu_op    = funct_alu(funct3, 1'b0);
            end
            LOAD:
            begin
                nxt.reg_write = 1'b1;
                nxt.mem_read  = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            STORE:
            begin
                nxt.mem_write = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH:
            begin
                nxt.is_branch = 1'b1;
                nxt.branch_ne = funct3[0]; // bne vs beq
                nxt.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};
            end
            SYSTEM:  nxt.is_halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (wb_i.valid && wb_i.reg_write && wb_i.rd != '0)
            regs[wb_i.rd] <= wb_i.data;
    end

    always_ff @(posedge sys_clk_i or posedge sys_reset_i)
    begin
        if (sys_reset_i)
            id_ex_o <= '0;
        else if (redirect_i.taken || stall_o)
            id_ex_o <= '0; // bubble
        else
            id_ex_o <= nxt;
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic               sys_clk_i,
    input  logic               sys_reset_i,
    input  rv_pkg::id_ex_t     id_ex_i,
    input  rv_pkg::wb_t        wb_i,
    output rv_pkg::redirect_t  redirect_o,
    output rv_pkg::ex_mem_t    ex_mem_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            operands_equal;
    logic            branch_taken;

    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] src,
                                            input logic [XLEN-1:0]   reg_val);
        logic [XLEN-1:0] val;
        if (src == '0)
            val = reg_val;
        else if (ex_mem_o.valid && ex_mem_o.reg_write && ex_mem_o.rd == src)
            val = ex_mem_o.alu_result; // youngest producer first
        else if (wb_i.valid && wb_i.reg_write && wb_i.rd == src)
            val = wb_i.data;
        else
            val = reg_val;
        return val;
    endfunction

    assign op_a     = fwd(id_ex_i.rs1, id_ex_i.rs1_data);
    assign op_b_reg = fwd(id_ex_i.rs2, id_ex_i.rs2_data);
    assign op_b     = id_ex_i.use_imm ? id_ex_i.imm : op_b_reg;

    always_comb
    begin
        case (id_ex_i.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    assign operands_equal = (op_a == op_b_reg);
    assign branch_taken   = id_ex_i.valid && id_ex_i.is_branch
                            && (id_ex_i.branch_ne ^ operands_equal);

    assign redirect_o.taken  = branch_taken;
    assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge sys_clk_i or posedge sys_reset_i)
    begin
        if (sys_reset_i)
            ex_mem_o <= '0;
        else
        begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.alu_result <= alu_result;
            ex_mem_o.store_data <= op_b_reg;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.reg_write  <= id_ex_i.valid && id_ex_i.reg_write;
            ex_mem_o.mem_read   <= id_ex_i.valid && id_ex_i.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.valid && id_ex_i.mem_write;
            ex_mem_o.is_halt    <= id_ex_i.valid && id_ex_i.is_halt;
        end
    end

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                        sys_clk_i,
    input  logic                        sys_reset_i,
    input  rv_pkg::ex_mem_t             ex_mem_i,
    input  logic                        dmem_we_i,
    input  logic [rv_pkg::DMEM_AW-1:0]  dmem_addr_i,
    input  logic [rv_pkg::XLEN-1:0]     dmem_wdata_i,
    output logic [rv_pkg::XLEN-1:0]     dmem_rdata_o,
    output rv_pkg::wb_t                 wb_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;
    logic [XLEN-1:0]    load_data;

    assign word_idx     = ex_mem_i.alu_result[DMEM_AW+1:2]; // word address
    assign load_data    = dmem[word_idx];
    assign dmem_rdata_o = dmem[dmem_addr_i];

    always_ff @(posedge sys_clk_i)
    begin
        if (ex_mem_i.valid && ex_mem_i.mem_write)
            dmem[word_idx] <= ex_mem_i.store_data;
        else if (dmem_we_i)
            dmem[dmem_addr_i] <= dmem_wdata_i; // host port, core idle
    end

    always_ff @(posedge sys_clk_i or posedge sys_reset_i)
    begin
        if (sys_reset_i)
            wb_o <= '0;
        else
        begin
            wb_o.valid     <= ex_mem_i.valid;
            wb_o.rd        <= ex_mem_i.rd;
            wb_o.reg_write <= ex_mem_i.valid && ex_mem_i.reg_write;
            wb_o.data      <= ex_mem_i.mem_read ? load_data : ex_mem_i.alu_result;
            wb_o.is_halt   <= ex_mem_i.valid && ex_mem_i.is_halt;
        end
    end

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                       sys_clk,
    input  logic                       sys_reset,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [rv_pkg::APB_AW-1:0]  paddr_i,
    input  logic [rv_pkg::XLEN-1:0]    pwdata_i,
    output logic [rv_pkg::XLEN-1:0]    prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);
    import rv_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    redirect_t       redirect;
    logic            stall;
    logic            run;
    logic            done;
    logic            access;
    logic            in_imem;
    logic            in_dmem;
    logic            in_reg;
    logic            in_ctrl;
    logic            mem_region;
    logic [XLEN-1:0] imem_rdata;
    logic [XLEN-1:0] dmem_rdata;
    logic [XLEN-1:0] reg_rdata;
    logic [XLEN-1:0] rdata;

    assign access     = psel_i & penable_i;
    assign in_imem    = paddr_i[APB_AW-1:8] == IMEM_BASE[APB_AW-1:8];
    assign in_dmem    = paddr_i[APB_AW-1:8] == DMEM_BASE[APB_AW-1:8];
    assign in_reg     = paddr_i[APB_AW-1:7] == REG_BASE[APB_AW-1:7]; // 32 regs only
    assign in_ctrl    = paddr_i == CTRL_ADDR;
    assign mem_region = in_imem | in_dmem | in_reg;

    assign pready_o  = 1'b1; // no wait states
    assign pslverr_o = access && ((mem_region && run) || !(mem_region || in_ctrl));

    always_comb
    begin
        rdata = '0;
        if (in_imem)
            rdata = imem_rdata;
        else if (in_dmem)
            rdata = dmem_rdata;
        else if (in_reg)
            rdata = reg_rdata;
        else if (in_ctrl)
        begin
            rdata[CTRL_RUN_BIT]  = run;
            rdata[CTRL_DONE_BIT] = done;
        end
    end

    assign prdata_o = (access && !pwrite_i && !pslverr_o) ? rdata : '0;

    always_ff @(posedge sys_clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            run  <= 1'b0;
            done <= 1'b0;
        end
        else if (wb.valid && wb.is_halt)
        begin
            run  <= 1'b0; // ebreak retired
            done <= 1'b1;
        end
        else if (access && pwrite_i && in_ctrl && pwdata_i[CTRL_RUN_BIT])
        begin
            run  <= 1'b1;
            done <= 1'b0;
        end
    end

    fetch_stage u_fetch (
        .sys_clk_i    (sys_clk),
        .sys_reset_i  (sys_reset),
        .run_i        (run),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .imem_we_i    (access && pwrite_i && in_imem && !run),
        .imem_addr_i  (paddr_i[IMEM_AW+1:2]),
        .imem_wdata_i (pwdata_i),
        .imem_rdata_o (imem_rdata),
        .if_id_o      (if_id)
    );

    decode_stage u_decode (
        .sys_clk_i      (sys_clk),
        .sys_reset_i    (sys_reset),
        .if_id_i        (if_id),
        .redirect_i     (redirect),
        .wb_i           (wb),
        .dbg_reg_addr_i (paddr_i[REG_AW+1:2]),
        .dbg_reg_data_o (reg_rdata),
        .stall_o        (stall),
        .id_ex_o        (id_ex)
    );

    execute_stage u_execute (
        .sys_clk_i   (sys_clk),
        .sys_reset_i (sys_reset),
        .id_ex_i     (id_ex),
        .wb_i        (wb),
        .redirect_o  (redirect),
        .ex_mem_o    (ex_mem)
    );

    memory_stage u_memory (
        .sys_clk_i    (sys_clk),
        .sys_reset_i  (sys_reset),
        .ex_mem_i     (ex_mem),
        .dmem_we_i    (access && pwrite_i && in_dmem && !run),
        .dmem_addr_i  (paddr_i[DMEM_AW+1:2]),
        .dmem_wdata_i (pwdata_i),
        .dmem_rdata_o (dmem_rdata),
        .wb_o         (wb)
    );

endmodule

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int CLK_HALF        = 50;
    localparam int NUM_RANDOM      = 8;
    localparam int NUM_PROGS       = NUM_RANDOM + 2;
    localparam int APB_XFERS       = 300; // per program, preload plus readback
    localparam int WATCHDOG_CYCLES =
        NUM_PROGS * ((IMEM_DEPTH + 40) * 4 + APB_XFERS * 3) + 100;
    localparam int IMEM_ADDR       = int'(IMEM_BASE);
    localparam int DMEM_ADDR       = int'(DMEM_BASE);
    localparam int REG_ADDR        = int'(REG_BASE);
    localparam int CTRL            = int'(CTRL_ADDR);

    logic              sys_clk = 1'b0;
    logic              sys_reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [XLEN-1:0]   pwdata;
    logic [XLEN-1:0]   prdata;
    logic              pready;
    logic              pslverr;
    logic [15:0]       lfsr;
    logic [XLEN-1:0]   prog [IMEM_DEPTH];
    int                prog_len;
    logic [XLEN-1:0]   mregs [32]; // ISA model state
    logic [XLEN-1:0]   mdmem [DMEM_DEPTH];

    rv_core_top dut (
        .sys_clk   (sys_clk),
        .sys_reset (sys_reset),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #CLK_HALF sys_clk = ~sys_clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("error: %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else
        begin
            $display("%s", what);
            abort_run();
        end
    endtask

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd, input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3, input logic [6:0] op);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3, input logic [6:0] op);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op};
    endfunction

    function automatic int pick_funct3(input int sel);
        case (sel)
            2:       return 7; // and
            3:       return 6; // or
            4:       return 4; // xor
            5:       return 2; // slt
            default: return 0; // add or sub
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog[prog_len[5:0]] = instr;
        prog_len++;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 5'd0)
            mregs[rd] = val;
    endtask

    task automatic run_model();
        int          pc;
        int          steps;
        bit          halt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        pc    = 0;
        steps = 0;
        halt  = 1'b0;
        while (!halt)
        begin
            ins   = prog[pc[7:2]];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            pc    = pc + 4;
            case (ins[6:0])
                OP:     write_reg(ins[11:7], alu_ref(ins[14:12], ins[30], a, b));
                OP_IMM: write_reg(ins[11:7], alu_ref(ins[14:12], 1'b0, a, imm_i));
                LOAD:
                begin
                    addr = a + imm_i;
                    write_reg(ins[11:7], mdmem[addr[DMEM_AW+1:2]]);
                end
                STORE:
                begin
                    addr = a + imm_s;
                    mdmem[addr[DMEM_AW+1:2]] = b;
                end
                BRANCH:
                begin
                    if ((a == b) != ins[12]) // funct3 bit 0 selects bne
                        pc = pc - 4 + int'(imm_b);
                end
                SYSTEM:  halt = 1'b1;
                default: check_true(1'b0, "model met an opcode outside the subset");
            endcase
            steps++;
            check_true(steps <= IMEM_DEPTH, "model ran past the end of the program");
        end
    endtask

    task automatic apb_xfer(input bit is_write, input int addr, input logic [31:0] wdata,
                            input bit exp_err, output logic [31:0] rdata);
        @(posedge sys_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr[APB_AW-1:0];
        pwdata  = wdata;
        @(posedge sys_clk);
        #1;
        penable = 1'b1;
        @(negedge sys_clk); // access phase, outputs settled
        rdata = prdata;
        check_value("pready", {31'b0, pready}, 32'd1);
        check_value($sformatf("pslverr at %h", addr), {31'b0, pslverr}, {31'b0, exp_err});
        @(posedge sys_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic gen_init_prog();
        prog_len = 0;
        emit(enc_i(4 * rand_bits(5), 0, 0, 31, OP_IMM)); // x31 is the load/store base
        for (int r = 1; r < 31; r++)
            emit(enc_i(rand_bits(12), 0, 0, r, OP_IMM));
        emit(enc_i(1, 0, 0, 0, SYSTEM));
    endtask

    task automatic gen_shadow_prog();
        prog_len = 0;
        emit(enc_i(5, 0, 0, 1, OP_IMM));
        emit(enc_b(12, 0, 1, 1, BRANCH)); // bne, skips two
        emit(enc_i(9, 0, 0, 3, OP_IMM));
        emit(enc_i(1, 0, 0, 0, SYSTEM)); // ebreak never fetched
        emit(enc_i(7, 1, 0, 2, OP_IMM));
        emit(enc_b(8, 2, 2, 0, BRANCH));
        emit(enc_i(1, 0, 0, 0, SYSTEM)); // in IF/ID when the beq resolves
        emit(enc_i(3, 2, 0, 4, OP_IMM)); // skipped if that ebreak retired
        emit(enc_i(1, 0, 0, 0, SYSTEM));
    endtask

    task automatic gen_random_prog();
        int n;
        int kind;
        int sel;
        int rd;
        int rs1;
        int rs2;
        int prev_rd;
        int target;
        prog_len = 0;
        n        = 24 + rand_bits(4);
        prev_rd  = 1;
        while (prog_len < n)
        begin
            kind = rand_bits(3);
            rd   = 1 + rand_bits(5) % 30;
            rs1  = rand_bits(1) ? prev_rd : rand_bits(5); // dependent chains
            rs2  = rand_bits(1) ? prev_rd : rand_bits(5);
            case (kind)
                0, 1:
                begin
                    sel = rand_bits(3) % 6;
                    emit(enc_r((sel == 1) ? 32 : 0, rs2, rs1, pick_funct3(sel), rd, OP));
                    prev_rd = rd;
                end
                2, 3:
                begin
                    sel = rand_bits(2);
                    sel = (sel == 0) ? 0 : sel + 1;
                    emit(enc_i(rand_bits(12), rs1, pick_funct3(sel), rd, OP_IMM));
                    prev_rd = rd;
                end
                5: emit(enc_s(4 * rand_bits(6), rs2, 31, 2, STORE));
                6:
                begin
                    target = prog_len + 2 + rand_bits(2);
                    if (target > n)
                        target = n;
                    rs2 = rand_bits(1) ? rs1 : rs2;
                    emit(enc_b(4 * (target - prog_len), rs2, rs1, rand_bits(1), BRANCH));
                end
                default:
                begin
                    emit(enc_i(4 * rand_bits(6), 31, 2, rd, LOAD)); // often a load-use pair
                    prev_rd = rd;
                end
            endcase
        end
        emit(enc_i(1, 0, 0, 0, SYSTEM));
    endtask

    task automatic run_and_check(input bit poke);
        logic [XLEN-1:0] data;
        for (int i = 0; i < DMEM_DEPTH; i++)
        begin
            mdmem[i[5:0]] = rand_bits(32);
            apb_xfer(1'b1, DMEM_ADDR + 4 * i, mdmem[i[5:0]], 1'b0, data);
        end
        for (int i = 0; i < prog_len; i++)
            apb_xfer(1'b1, IMEM_ADDR + 4 * i, prog[i[5:0]], 1'b0, data);
        apb_xfer(1'b1, CTRL, 32'h1 << CTRL_RUN_BIT, 1'b0, data);
        if (poke)
        begin
            apb_xfer(1'b0, CTRL, 32'h0, 1'b0, data);
            check_value("prdata ctrl while running", data, 32'h1);
            apb_xfer(1'b1, DMEM_ADDR + 20, ~mdmem[6'd5], 1'b1, data);
            apb_xfer(1'b0, REG_ADDR + 4, 32'h0, 1'b1, data);
            check_value("prdata reg while running", data, 32'h0);
            apb_xfer(1'b0, IMEM_ADDR, 32'h0, 1'b1, data);
            check_value("prdata imem while running", data, 32'h0);
        end
        do
            apb_xfer(1'b0, CTRL, 32'h0, 1'b0, data);
        while (!data[CTRL_DONE_BIT]);
        check_value("prdata ctrl after done", data, 32'h2);
        run_model();
        for (int i = 0; i < 32; i++)
        begin
            apb_xfer(1'b0, REG_ADDR + 4 * i, 32'h0, 1'b0, data);
            check_value($sformatf("prdata x%0d", i), data, mregs[i[4:0]]);
        end
        for (int i = 0; i < DMEM_DEPTH; i++)
        begin
            apb_xfer(1'b0, DMEM_ADDR + 4 * i, 32'h0, 1'b0, data);
            check_value($sformatf("prdata dmem[%0d]", i), data, mdmem[i[5:0]]);
        end
        for (int i = 0; i < prog_len; i++)
        begin
            apb_xfer(1'b0, IMEM_ADDR + 4 * i, 32'h0, 1'b0, data);
            check_value($sformatf("prdata imem[%0d]", i), data, prog[i[5:0]]);
        end
    endtask

    initial
    begin
        logic [XLEN-1:0] data;
        sys_reset = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lfsr      = 16'd62097;
        for (int i = 0; i < 32; i++)
            mregs[i[4:0]] = '0;
        repeat (4) @(posedge sys_clk);
        #1;
        sys_reset = 1'b0;

        apb_xfer(1'b0, CTRL, 32'h0, 1'b0, data);
        check_value("prdata ctrl after reset", data, 32'h0);
        apb_xfer(1'b0, CTRL + 4, 32'h0, 1'b1, data);
        check_value("prdata unmapped", data, 32'h0);
        apb_xfer(1'b0, REG_ADDR + 'h80, 32'h0, 1'b1, data); // past x31
        apb_xfer(1'b1, 'h400, 32'hdead_beef, 1'b1, data);

        gen_init_prog();
        run_and_check(1'b1);
        gen_shadow_prog();
        run_and_check(1'b0);
        for (int p = 0; p < NUM_RANDOM; p++)
        begin
            gen_random_prog();
            run_and_check(1'b0); // each one reloads imem and restarts
        end
        $display("PASS: all tests");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("timeout after %0d cycles, the core or the bus stopped responding",
                 WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

/* all.f */
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core_top.sv
verification/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rv_core -o tb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
